// File: compile.f
hw/fifo_pkg.sv
hw/fifo_ctrl_fsm.sv
hw/fifo_mem.sv
hw/pkt_producer.sv
hw/pkt_consumer.sv
hw/pkt_fifo_top.sv
verif/pkt_checker.sv
verif/tb_pkt_fifo.sv

// File: hw/fifo_ctrl_fsm.sv
module fifo_ctrl_fsm
    import fifo_pkg::*;
(
    input  logic               wr_clk,
    input  logic               rd_srst,

    // Write side
    input  logic               i_wr,
    output logic               o_wr_safe,
    output logic               o_wr_rdy,
    output logic [PTR_WID-1:0] o_wr_ptr,
    output logic [CNT_WID-1:0] o_count,
    output logic               o_full,
    output logic               o_oflow,

    // Read side
    input  logic               i_rd,
    output logic               o_rd_safe,
    output logic [PTR_WID-1:0] o_rd_ptr,
    output logic               o_empty,
    output logic               o_uflow
);

    logic [CNT_WID-1:0] wr_ptr_q;
    logic [CNT_WID-1:0] rd_ptr_q;
    logic [CNT_WID-1:0] cnt_raw;
    logic [CNT_WID-1:0] cnt_nxt;

    // ------------------------------------------------------------------
    // Write pointer
    // ------------------------------------------------------------------
    // Strobe is blocked while not ready
    assign o_wr_safe = i_wr && o_wr_rdy;
    assign o_oflow   = i_wr && !o_wr_rdy;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            wr_ptr_q <= '0;
        end else if (o_wr_safe) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    assign o_wr_ptr = wr_ptr_q[PTR_WID-1:0];

    // ------------------------------------------------------------------
    // Read pointer
    // ------------------------------------------------------------------
    assign o_rd_safe = i_rd && !o_empty;
    assign o_uflow   = i_rd && o_empty;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rd_ptr_q <= '0;
        end else if (o_rd_safe) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    assign o_rd_ptr = rd_ptr_q[PTR_WID-1:0];

    // ------------------------------------------------------------------
    // Count, full, ready and empty
    // ------------------------------------------------------------------
    // Pointer difference, one extra bit tells full from empty
    assign cnt_raw = wr_ptr_q - rd_ptr_q;

    // Occupancy after this edge; both strobes share one clock
    assign cnt_nxt = cnt_raw + CNT_WID'(o_wr_safe) - CNT_WID'(o_rd_safe);

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            o_count  <= '0;
            o_full   <= 1'b0;
            o_wr_rdy <= 1'b0;
        end else begin
            o_count  <= cnt_nxt;
            o_full   <= (cnt_nxt == CNT_WID'(DEPTH));
            o_wr_rdy <= (cnt_nxt < CNT_WID'(DEPTH));
        end
    end

    // Empty follows reads at once and writes one cycle late
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            o_empty <= 1'b1;
        end else if (o_rd_safe) begin
            o_empty <= (cnt_raw <= CNT_WID'(1));
        end else begin
            o_empty <= (cnt_raw == '0);
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // Producer credits must keep every write inside the buffer
    a_no_oflow : assert property (
        @(posedge wr_clk) disable iff (rd_srst) !o_oflow
    ) else $error("fifo_ctrl_fsm: write while not ready");

    // Consumer only reads when empty is low
    a_no_uflow : assert property (
        @(posedge wr_clk) disable iff (rd_srst) !o_uflow
    ) else $error("fifo_ctrl_fsm: read while empty");

endmodule : fifo_ctrl_fsm

// File: hw/fifo_mem.sv
module fifo_mem
    import fifo_pkg::*;
(
    input  logic               wr_clk,

    // Write port
    input  logic               i_we,
    input  logic [PTR_WID-1:0] i_waddr,
    input  fifo_word_t         i_wdata,

    // Read port
    input  logic               i_re,
    input  logic [PTR_WID-1:0] i_raddr,
    output fifo_word_t         o_rdata
);

    fifo_word_t mem [DEPTH];

    // Write in the cycle of the strobe
    always_ff @(posedge wr_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Registered read, data one cycle after i_re
    always_ff @(posedge wr_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule : fifo_mem

// File: hw/fifo_pkg.sv
package fifo_pkg;

    // ------------------------------------------------------------------
    // Buffer sizing
    // ------------------------------------------------------------------
    localparam int DEPTH    = 16;
    localparam int PTR_WID  = 4;
    localparam int CNT_WID  = 5;
    localparam int WORD_WID = 16;

    // Largest payload length in a command
    localparam int MAX_LEN = 15;

    // Payload base is the packet id moved up by this many bits
    localparam int PAY_BASE_SHIFT = 4;

    // Producer state encoding
    localparam logic [1:0] PST_IDLE = 2'd0;
    localparam logic [1:0] PST_HDR  = 2'd1;
    localparam logic [1:0] PST_PAY  = 2'd2;

    // One buffer word, seen as a header or as payload
    typedef union packed {
        struct packed {
            logic [7:0] pkt_id;
            logic [7:0] pkt_len;
        } hdr;
        struct packed {
            logic [WORD_WID-1:0] data;
        } pay;
    } fifo_word_t;

    // Payload word k of packet id, wraps at 16 bits
    function automatic logic [WORD_WID-1:0] pay_value(input logic [7:0] id,
                                                     input logic [7:0] k);
        return (WORD_WID'(id) << PAY_BASE_SHIFT) + WORD_WID'(k);
    endfunction

endpackage : fifo_pkg

// File: hw/pkt_consumer.sv
module pkt_consumer
    import fifo_pkg::*;
(
    input  logic                wr_clk,
    input  logic                rd_srst,

    // Buffer read port
    input  logic                i_empty,
    output logic                o_rd_en,
    input  fifo_word_t          i_rd_data,

    // Back-pressure and credit return
    input  logic                i_stall,
    output logic                o_credit_ret,

    // Per-packet result
    output logic                o_pkt_valid,
    output logic [7:0]          o_pkt_id,
    output logic [7:0]          o_pkt_len,
    output logic [WORD_WID-1:0] o_pkt_sum
);

    logic                rd_vld_q;
    logic                open_q;
    logic                pkt_vld_q;
    logic [7:0]          id_q;
    logic [7:0]          len_q;
    logic [7:0]          rem_q;
    logic [WORD_WID-1:0] sum_q;
    logic                hdr_seen;
    logic                last_seen;

    // ------------------------------------------------------------------
    // Read scheduling
    // ------------------------------------------------------------------
    assign o_rd_en      = !i_empty && !i_stall;
    // Every issued read is accepted, so the credit goes back at once
    assign o_credit_ret = o_rd_en;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    // No open packet means the returning word is a header
    assign hdr_seen  = rd_vld_q && !open_q;
    assign last_seen = rd_vld_q && open_q && (rem_q == 8'd1);

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rd_vld_q  <= 1'b0;
            open_q    <= 1'b0;
            pkt_vld_q <= 1'b0;
        end else begin
            rd_vld_q  <= o_rd_en;
            pkt_vld_q <= (hdr_seen && (i_rd_data.hdr.pkt_len == 8'd0)) || last_seen;
            if (hdr_seen && (i_rd_data.hdr.pkt_len != 8'd0)) begin
                open_q <= 1'b1;
            end else if (last_seen) begin
                open_q <= 1'b0;
            end
        end
    end

    // Packet fields and running sum
    always_ff @(posedge wr_clk) begin
        if (hdr_seen) begin
            id_q  <= i_rd_data.hdr.pkt_id;
            len_q <= i_rd_data.hdr.pkt_len;
            rem_q <= i_rd_data.hdr.pkt_len;
            sum_q <= '0;
        end else if (rd_vld_q) begin
            sum_q <= sum_q + i_rd_data.pay.data;
            rem_q <= rem_q - 8'd1;
        end
    end

    // Fields stay stable during the pulse cycle
    assign o_pkt_valid = pkt_vld_q;
    assign o_pkt_id    = id_q;
    assign o_pkt_len   = len_q;
    assign o_pkt_sum   = sum_q;

endmodule : pkt_consumer

// File: hw/pkt_fifo_top.sv
module pkt_fifo_top
    import fifo_pkg::*;
(
    input  logic                wr_clk,
    input  logic                rd_srst,

    input  logic                i_cmd_valid,
    input  logic [7:0]          i_cmd_id,
    input  logic [7:0]          i_cmd_len,
    output logic                o_cmd_ready,

    input  logic                i_stall,
    output logic                o_pkt_valid,
    output logic [7:0]          o_pkt_id,
    output logic [7:0]          o_pkt_len,
    output logic [WORD_WID-1:0] o_pkt_sum,

    output logic                o_full,
    output logic                o_oflow,
    output logic                o_uflow
);

    logic               wr_en;
    fifo_word_t         wr_data;
    logic               wr_safe;
    logic [PTR_WID-1:0] wr_ptr;
    logic               rd_en;
    fifo_word_t         rd_data;
    logic               rd_safe;
    logic [PTR_WID-1:0] rd_ptr;
    logic               empty;
    logic               credit_ret;

    pkt_producer u_producer (
        .wr_clk       (wr_clk),
        .rd_srst      (rd_srst),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_id     (i_cmd_id),
        .i_cmd_len    (i_cmd_len),
        .o_cmd_ready  (o_cmd_ready),
        .o_wr_en      (wr_en),
        .o_wr_data    (wr_data),
        .i_credit_ret (credit_ret)
    );

    fifo_ctrl_fsm u_ctrl (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .i_wr      (wr_en),
        .o_wr_safe (wr_safe),
        .o_wr_rdy  (),
        .o_wr_ptr  (wr_ptr),
        .o_count   (),
        .o_full    (o_full),
        .o_oflow   (o_oflow),
        .i_rd      (rd_en),
        .o_rd_safe (rd_safe),
        .o_rd_ptr  (rd_ptr),
        .o_empty   (empty),
        .o_uflow   (o_uflow)
    );

    fifo_mem u_mem (
        .wr_clk  (wr_clk),
        .i_we    (wr_safe),
        .i_waddr (wr_ptr),
        .i_wdata (wr_data),
        .i_re    (rd_safe),
        .i_raddr (rd_ptr),
        .o_rdata (rd_data)
    );

    pkt_consumer u_consumer (
        .wr_clk       (wr_clk),
        .rd_srst      (rd_srst),
        .i_empty      (empty),
        .o_rd_en      (rd_en),
        .i_rd_data    (rd_data),
        .i_stall      (i_stall),
        .o_credit_ret (credit_ret),
        .o_pkt_valid  (o_pkt_valid),
        .o_pkt_id     (o_pkt_id),
        .o_pkt_len    (o_pkt_len),
        .o_pkt_sum    (o_pkt_sum)
    );

endmodule : pkt_fifo_top

// File: hw/pkt_producer.sv
module pkt_producer
    import fifo_pkg::*;
(
    input  logic       wr_clk,
    input  logic       rd_srst,

    // Command port
    input  logic       i_cmd_valid,
    input  logic [7:0] i_cmd_id,
    input  logic [7:0] i_cmd_len,
    output logic       o_cmd_ready,

    // Buffer write port
    output logic       o_wr_en,
    output fifo_word_t o_wr_data,

    // One credit per word read by the consumer
    input  logic       i_credit_ret
);

    logic [1:0]         state_q;
    logic [1:0]         state_nxt;
    logic [7:0]         id_q;
    logic [7:0]         len_q;
    logic [7:0]         word_cnt_q;
    logic [CNT_WID-1:0] credit_q;
    logic               cmd_rdy_q;
    logic               accept;
    logic               last_pay;

    assign o_cmd_ready = cmd_rdy_q;
    assign accept      = i_cmd_valid && cmd_rdy_q;

    // Write whenever a word is pending and a credit is held
    assign o_wr_en  = (state_q != PST_IDLE) && (credit_q != '0);
    assign last_pay = (word_cnt_q == len_q - 8'd1);

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            PST_IDLE: if (accept) state_nxt = PST_HDR;
            PST_HDR:  if (o_wr_en) state_nxt = (len_q == 8'd0) ? PST_IDLE : PST_PAY;
            PST_PAY:  if (o_wr_en && last_pay) state_nxt = PST_IDLE;
            default:  state_nxt = PST_IDLE;
        endcase
    end

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            state_q   <= PST_IDLE;
            cmd_rdy_q <= 1'b0;
            credit_q  <= CNT_WID'(DEPTH);
        end else begin
            state_q   <= state_nxt;
            cmd_rdy_q <= (state_nxt == PST_IDLE);
            // Spend and return in one cycle cancel out
            credit_q  <= credit_q - CNT_WID'(o_wr_en) + CNT_WID'(i_credit_ret);
        end
    end

    // Command fields and word index
    always_ff @(posedge wr_clk) begin
        if (accept) begin
            id_q       <= i_cmd_id;
            len_q      <= i_cmd_len;
            word_cnt_q <= '0;
        end else if ((state_q == PST_PAY) && o_wr_en) begin
            word_cnt_q <= word_cnt_q + 8'd1;
        end
    end

    // Header word first, then the payload words
    always_comb begin
        o_wr_data = '0;
        if (state_q == PST_HDR) begin
            o_wr_data.hdr.pkt_id  = id_q;
            o_wr_data.hdr.pkt_len = len_q;
        end else begin
            o_wr_data.pay.data = pay_value(id_q, word_cnt_q);
        end
    end

    a_credit_max : assert property (
        @(posedge wr_clk) disable iff (rd_srst) credit_q <= CNT_WID'(DEPTH)
    ) else $error("pkt_producer: credit count above DEPTH");

    a_cmd_len : assert property (
        @(posedge wr_clk) disable iff (rd_srst) accept |-> (i_cmd_len <= 8'(MAX_LEN))
    ) else $error("pkt_producer: command length above MAX_LEN");

endmodule : pkt_producer

// File: verif/pkt_checker.sv
module pkt_checker
    import fifo_pkg::*;
(
    input logic                wr_clk,
    input logic                rd_srst,
    input logic                i_cmd_valid,
    input logic                i_cmd_ready,
    input logic [7:0]          i_cmd_id,
    input logic [7:0]          i_cmd_len,
    input logic                i_stall,
    input logic                i_pkt_valid,
    input logic [7:0]          i_pkt_id,
    input logic [7:0]          i_pkt_len,
    input logic [WORD_WID-1:0] i_pkt_sum,
    input logic                i_full,
    input logic                i_oflow,
    input logic                i_uflow
);

    // Entry layout {expect full, sum, len, id}
    logic [32:0] pend_q [$];
    logic [32:0] open_q [$];
    logic [32:0] ent;
    int          err_cnt   = 0;
    int          n_results = 0;
    int          full_exp  = 0;
    int          full_runs = 0;
    int          low_cnt   = 0;
    bit          started   = 1'b0;
    bit          in_stall  = 1'b0;
    bit          armed     = 1'b0;
    bit          arm_next  = 1'b0;
    bit          full_seen = 1'b0;

    task automatic push_expected(input logic [7:0] id, input logic [7:0] len,
                                 input logic [15:0] sum, input bit full);
        pend_q.push_back({full, sum, len, id});
        if (full) full_exp++;
    endtask

    task automatic fail_plain(input string msg);
        $display("** Error: %s at time %0t", msg, $time);
        err_cnt++;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error [%s]: expected %0h, actual %0h", name, exp, act);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // Sampled mid-cycle, away from the driving edge
    // ------------------------------------------------------------------
    always @(negedge wr_clk) begin
        if (rd_srst) begin
            low_cnt = 0;
        end else begin
            low_cnt++;
            if (low_cnt == 2 && i_cmd_ready !== 1'b1) fail_plain("o_cmd_ready low after reset");
            if (i_oflow !== 1'b0) fail_plain("overflow flag seen high");
            if (i_uflow !== 1'b0) fail_plain("underflow flag seen high");
            if (!started && (i_pkt_valid || i_full)) fail_plain("activity before first command");
            // A stall right after a full-length command must fill the buffer
            if (i_stall) begin
                if (!in_stall) begin
                    armed     = arm_next;
                    full_seen = 1'b0;
                end
                full_seen = full_seen || i_full;
            end else if (in_stall && armed) begin
                full_runs++;
                if (!full_seen) fail_plain("buffer never went full during a long stall");
            end
            in_stall = i_stall;
            if (i_pkt_valid) begin
                if (open_q.size() == 0) begin
                    fail_plain("result with no outstanding command");
                end else begin
                    ent = open_q.pop_front();
                    compare($sformatf("pkt %0d id", n_results), ent[7:0], i_pkt_id);
                    compare($sformatf("pkt %0d len", n_results), ent[15:8], i_pkt_len);
                    compare($sformatf("pkt %0d sum", n_results), ent[31:16], i_pkt_sum);
                end
                n_results++;
            end
            arm_next = 1'b0;
            if (i_cmd_valid && i_cmd_ready) begin
                started = 1'b1;
                if (pend_q.size() == 0) begin
                    fail_plain("command accepted with no table entry");
                end else begin
                    // Result id and length follow the command as accepted
                    ent      = pend_q.pop_front();
                    arm_next = ent[32];
                    open_q.push_back({ent[32:16], i_cmd_len, i_cmd_id});
                end
            end
        end
    end

    task automatic check_end(input int n_exp);
        if (n_results != n_exp) begin
            fail_plain($sformatf("%0d results, %0d expected", n_results, n_exp));
        end
        if (open_q.size() != 0 || pend_q.size() != 0) fail_plain("commands left without a result");
        if (full_runs != full_exp) begin
            fail_plain($sformatf("%0d of %0d full stalls", full_runs, full_exp));
        end
    endtask

endmodule : pkt_checker

// File: verif/tb_pkt_fifo.sv
module tb_pkt_fifo
    import fifo_pkg::*;
();

    localparam int NUM_ENT = 12;

    logic                wr_clk;
    logic                rd_srst;
    logic                i_cmd_valid;
    logic [7:0]          i_cmd_id;
    logic [7:0]          i_cmd_len;
    logic                o_cmd_ready;
    logic                i_stall;
    logic                o_pkt_valid;
    logic [7:0]          o_pkt_id;
    logic [7:0]          o_pkt_len;
    logic [WORD_WID-1:0] o_pkt_sum;
    logic                o_full;
    logic                o_oflow;
    logic                o_uflow;

    // Stimulus table with expected sums
    logic [7:0]  tbl_id    [NUM_ENT];
    logic [7:0]  tbl_len   [NUM_ENT];
    int          tbl_stall [NUM_ENT];
    logic [15:0] tbl_sum   [NUM_ENT];
    bit          tbl_full  [NUM_ENT];
    integer      seed;
    int          stall_total  = 0;
    int          limit_cycles = 0;

    pkt_fifo_top u_pkt_fifo_top (.*);

    pkt_checker u_chk (
        .wr_clk      (wr_clk),
        .rd_srst     (rd_srst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_ready (o_cmd_ready),
        .i_cmd_id    (i_cmd_id),
        .i_cmd_len   (i_cmd_len),
        .i_stall     (i_stall),
        .i_pkt_valid (o_pkt_valid),
        .i_pkt_id    (o_pkt_id),
        .i_pkt_len   (o_pkt_len),
        .i_pkt_sum   (o_pkt_sum),
        .i_full      (o_full),
        .i_oflow     (o_oflow),
        .i_uflow     (o_uflow)
    );

    initial begin
        wr_clk = 1'b0;
        forever #10 wr_clk = ~wr_clk;
    end

    task automatic set_entry(input int idx, input logic [7:0] id, input logic [7:0] len,
                             input int stall, input logic [15:0] sum, input bit full);
        tbl_id[idx]    = id;
        tbl_len[idx]   = len;
        tbl_stall[idx] = stall;
        tbl_sum[idx]   = sum;
        tbl_full[idx]  = full;
    endtask

    // Present one command, wait for it to be taken, then back-pressure
    task automatic apply_entry(input int idx);
        bit taken;
        u_chk.push_expected(tbl_id[idx], tbl_len[idx], tbl_sum[idx], tbl_full[idx]);
        i_cmd_valid = 1'b1;
        i_cmd_id    = tbl_id[idx];
        i_cmd_len   = tbl_len[idx];
        taken       = 1'b0;
        while (!taken) begin
            @(negedge wr_clk);
            taken = o_cmd_ready;
            @(posedge wr_clk);
            #2;
        end
        i_cmd_valid = 1'b0;
        i_stall     = (tbl_stall[idx] > 0);
        if (tbl_stall[idx] > 0) begin
            repeat (tbl_stall[idx]) @(posedge wr_clk);
            #2;
        end
        i_stall = 1'b0;
    endtask

    initial begin
        seed        = 86996;
        rd_srst     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_id    = '0;
        i_cmd_len   = '0;
        i_stall     = 1'b0;
        // idx, id, len, stall (-1 random), sum, buffer must fill
        set_entry(0, 8'h01, 3, 0, 16'h0033, 0);
        set_entry(1, 8'h02, 0, 0, 16'h0000, 0);
        set_entry(2, 8'h3C, 5, 4, 16'h12CA, 0);
        set_entry(3, 8'h7F, 15, 30, 16'h7779, 1);
        set_entry(4, 8'h80, 1, 0, 16'h0800, 0);
        set_entry(5, 8'hFF, 15, -1, 16'hEF79, 0);
        set_entry(6, 8'h55, 8, -1, 16'h2A9C, 0);
        set_entry(7, 8'h10, 15, 0, 16'h0F69, 0);
        set_entry(8, 8'h11, 15, 40, 16'h1059, 1);
        set_entry(9, 8'hA5, 0, -1, 16'h0000, 0);
        set_entry(10, 8'hC3, 12, 2, 16'h9282, 0);
        set_entry(11, 8'h00, 15, -1, 16'h0069, 0);
        for (int i = 0; i < NUM_ENT; i++) begin
            if (tbl_stall[i] < 0) tbl_stall[i] = $unsigned($random(seed)) % 20;
            stall_total += tbl_stall[i];
        end
        limit_cycles = 40 * NUM_ENT + stall_total + 16;
        repeat (16) @(posedge wr_clk);
        #2 rd_srst = 1'b0;
        // Idle gap to watch the outputs settle after reset
        repeat (4) @(posedge wr_clk);
        #2;
        for (int i = 0; i < NUM_ENT; i++) apply_entry(i);
        wait (u_chk.n_results >= NUM_ENT);
        repeat (20) @(posedge wr_clk);
        u_chk.check_end(NUM_ENT);
        $display("Packets %0d of %0d, errors %0d", u_chk.n_results, NUM_ENT, u_chk.err_cnt);
        if (u_chk.err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge wr_clk);
        $display("Run timed out before all packets completed (%0d cycles)", limit_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule : tb_pkt_fifo
